/* verilog/translator_pkg.sv */
// Shared widths, symbol constants and command/response structs; import into each translator block
package translator_pkg;

   // ----------------------------------------------------------------------
   // Symbol geometry
   // ----------------------------------------------------------------------
   // Bytes carried by one data word
   localparam int SYMBOLS_PER_WORD = 4;
   // Word to byte conversion is a left shift by this amount
   localparam int SYMBOL_SHIFT     = 2;
   localparam int DATA_W           = 32;

   // ----------------------------------------------------------------------
   // Address and burst-count widths
   // ----------------------------------------------------------------------
   // Master side counts in words
   localparam int AV_ADDR_W        = 16;
   localparam int AV_BURST_W       = 4;
   // Universal side counts in bytes
   localparam int UAV_ADDR_W       = 20;
   localparam int UAV_BURST_W      = 8;

   // Avalon-MM master command, word addressed
   typedef struct packed {
      logic                        write;
      logic                        read;
      logic [AV_ADDR_W-1:0]        address;
      logic [AV_BURST_W-1:0]       burstcount;
      logic [SYMBOLS_PER_WORD-1:0] byteenable;
      logic [DATA_W-1:0]           writedata;
   } av_cmd_t;

   // Universal command toward the interconnect, byte addressed
   typedef struct packed {
      logic                        write;
      logic                        read;
      logic [UAV_ADDR_W-1:0]       address;
      logic [UAV_BURST_W-1:0]      burstcount;
      logic [SYMBOLS_PER_WORD-1:0] byteenable;
      logic [DATA_W-1:0]           writedata;
   } uav_cmd_t;

   // Response path, same on both sides
   typedef struct packed {
      logic [DATA_W-1:0]           readdata;
      logic                        readdatavalid;
      logic [1:0]                  response;
      logic                        writeresponsevalid;
   } rsp_t;

endpackage

/* verilog/transfer_tracker.sv */
// Start-of-transfer and start-of-burst flag logic; instantiated by master_translator
`timescale 1ns/1ps

module transfer_tracker (
   input  logic clk,
   input  logic reset,
   input  logic req_write,
   input  logic req_read,
   input  logic uav_waitrequest,
   input  logic last_beat,
   output logic begin_transfer,
   output logic begin_burst
);

   // Set while the current request is stalled past its first cycle
   logic end_transfer;
   // Set inside a write burst after its first beat
   logic end_burst;
   // Write beat taken by the interconnect
   logic write_accepted;

   assign write_accepted = req_write && !uav_waitrequest;

   // ----------------------------------------------------------------------
   // Start of transfer
   // ----------------------------------------------------------------------
   assign begin_transfer = (req_write || req_read) && !end_transfer;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_transfer <= 1'b0;
      end else if (uav_waitrequest) begin
         // Mask further starts until this one is accepted
         end_transfer <= end_transfer || begin_transfer;
      end else begin
         end_transfer <= 1'b0;
      end
   end

   // ----------------------------------------------------------------------
   // Start of burst
   // ----------------------------------------------------------------------
   // Reads are one command, so every read start is a burst start
   assign begin_burst = req_read ? begin_transfer : (begin_transfer && !end_burst);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_burst <= 1'b0;
      end else if (req_read || (write_accepted && last_beat)) begin
         end_burst <= 1'b0;
      end else if (write_accepted) begin
         end_burst <= 1'b1;
      end
   end

   // ----------------------------------------------------------------------
   // Checks
   // ----------------------------------------------------------------------
   // A read never arrives inside an unfinished write burst
   assert property (@(posedge clk) disable iff (reset)
      end_burst |-> !req_read);

endmodule

/* verilog/burst_sequencer.sv */
// Word to byte command conversion with per-beat stepping; instantiated by master_translator
`timescale 1ns/1ps

module burst_sequencer
   import translator_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  av_cmd_t  av_cmd,
   input  logic     uav_waitrequest,
   input  logic     begin_transfer,
   input  logic     begin_burst,
   output uav_cmd_t uav_cmd,
   output logic     last_beat
);

   // One word expressed in byte units
   localparam logic [UAV_ADDR_W-1:0]  ADDR_STEP  = UAV_ADDR_W'(SYMBOLS_PER_WORD);
   localparam logic [UAV_BURST_W-1:0] COUNT_STEP = UAV_BURST_W'(SYMBOLS_PER_WORD);

   // Converted master values
   logic [UAV_ADDR_W-1:0]  addr_pre;
   logic [UAV_BURST_W-1:0] burst_pre;

   // Next-beat address and remaining byte count
   logic [UAV_ADDR_W-1:0]  addr_reg;
   logic [UAV_BURST_W-1:0] count_reg;

   // Stall tracking for first and later beats
   logic first_stalled;
   logic burst_stalled;

   // ----------------------------------------------------------------------
   // Unit conversion
   // ----------------------------------------------------------------------
   // Low bits zero, word index above them
   assign addr_pre = {{(UAV_ADDR_W - AV_ADDR_W - SYMBOL_SHIFT){1'b0}},
                      av_cmd.address, {SYMBOL_SHIFT{1'b0}}};
   assign burst_pre = {{(UAV_BURST_W - AV_BURST_W - SYMBOL_SHIFT){1'b0}},
                       av_cmd.burstcount, {SYMBOL_SHIFT{1'b0}}};

   // ----------------------------------------------------------------------
   // Output command
   // ----------------------------------------------------------------------
   always_comb begin
      uav_cmd.write      = av_cmd.write;
      uav_cmd.read       = av_cmd.read;
      uav_cmd.byteenable = av_cmd.byteenable;
      uav_cmd.writedata  = av_cmd.writedata;
      // First beat goes straight out and later beats come from the registers
      if (begin_burst) begin
         uav_cmd.address    = addr_pre;
         uav_cmd.burstcount = burst_pre;
      end else begin
         uav_cmd.address    = addr_reg;
         uav_cmd.burstcount = count_reg;
      end
   end

   // One word left in the active byte count
   assign last_beat = begin_burst ? (burst_pre == COUNT_STEP) : (count_reg == COUNT_STEP);

   // ----------------------------------------------------------------------
   // Per-beat registers
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         addr_reg  <= '0;
         count_reg <= '0;
      end else if (begin_burst || first_stalled) begin
         if (uav_waitrequest) begin
            // Stalled first beat keeps the converted values for the retry
            addr_reg  <= addr_pre;
            count_reg <= burst_pre;
         end else begin
            addr_reg  <= addr_pre + ADDR_STEP;
            count_reg <= burst_pre - COUNT_STEP;
         end
      end else if (begin_transfer || burst_stalled) begin
         // Later beats advance only when accepted
         if (!uav_waitrequest) begin
            addr_reg  <= addr_reg + ADDR_STEP;
            count_reg <= count_reg - COUNT_STEP;
         end
      end
   end

   // Remember a stall so the right register path stays selected
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         first_stalled <= 1'b0;
         burst_stalled <= 1'b0;
      end else if (begin_burst || first_stalled) begin
         first_stalled <= uav_waitrequest;
      end else if (begin_transfer || burst_stalled) begin
         burst_stalled <= uav_waitrequest;
      end
   end

   // ----------------------------------------------------------------------
   // Checks
   // ----------------------------------------------------------------------
   // Master holds its whole command across a stall
   assert property (@(posedge clk) disable iff (reset)
      ($past(uav_waitrequest) && ($past(av_cmd.write) || $past(av_cmd.read)))
      |-> (av_cmd == $past(av_cmd)));

   // A continuing write burst still has at least one word left
   assert property (@(posedge clk) disable iff (reset)
      (av_cmd.write && !begin_burst && (begin_transfer || burst_stalled))
      |-> (count_reg >= COUNT_STEP));

endmodule

/* verilog/master_translator.sv */
// Top level of the master translator; place between a bursting master and the interconnect
`timescale 1ns/1ps

module master_translator
   import translator_pkg::*;
(
   input  logic     clk,
   input  logic     reset,

   // Master side
   input  av_cmd_t  av_cmd,
   output logic     av_waitrequest,
   output rsp_t     av_rsp,

   // Interconnect side
   output uav_cmd_t uav_cmd,
   input  logic     uav_waitrequest,
   input  rsp_t     uav_rsp
);

   // ----------------------------------------------------------------------
   // Internal links between tracker and sequencer
   // ----------------------------------------------------------------------
   // First cycle of a request
   logic begin_transfer;
   // First beat of a burst
   logic begin_burst;
   // Active byte count is one word
   logic last_beat;

   // ----------------------------------------------------------------------
   // Response and back-pressure path
   // ----------------------------------------------------------------------
   // Read data, responses and waitrequest need no translation
   assign av_rsp         = uav_rsp;
   assign av_waitrequest = uav_waitrequest;

   // ----------------------------------------------------------------------
   // Transfer and burst start detection
   // ----------------------------------------------------------------------
   // Master request bits drive the tracker directly
   transfer_tracker u_transfer_tracker (
      .clk             (clk),
      .reset           (reset),
      .req_write       (av_cmd.write),
      .req_read        (av_cmd.read),
      .uav_waitrequest (uav_waitrequest),
      .last_beat       (last_beat),
      .begin_transfer  (begin_transfer),
      .begin_burst     (begin_burst)
   );

   // ----------------------------------------------------------------------
   // Command conversion
   // ----------------------------------------------------------------------
   // Word to byte units, per-beat address and remaining count
   burst_sequencer u_burst_sequencer (
      .clk             (clk),
      .reset           (reset),
      .av_cmd          (av_cmd),
      .uav_waitrequest (uav_waitrequest),
      .begin_transfer  (begin_transfer),
      .begin_burst     (begin_burst),
      .uav_cmd         (uav_cmd),
      .last_beat       (last_beat)
   );

endmodule

/* tb/tb_master_translator.sv */
// Directed testbench for master_translator; compile through vlog.f and run from the project root
`timescale 1ns/1ps

module tb_master_translator
   import translator_pkg::*;
();

   localparam int          CLK_PERIOD      = 100;
   localparam int          RESET_CYCLES    = 5;
   localparam int          NUM_TESTS       = 5;
   localparam int          CYCLES_PER_TEST = 400;
   localparam logic [15:0] LFSR_SEED       = 16'd49;
   // Galois taps for x^16 + x^14 + x^13 + x^11 + 1
   localparam logic [15:0] LFSR_TAPS       = 16'hB400;

   logic     clk;
   logic     reset;
   av_cmd_t  av_cmd;
   logic     av_waitrequest;
   rsp_t     av_rsp;
   uav_cmd_t uav_cmd;
   logic     uav_waitrequest;
   rsp_t     uav_rsp;

   // Stimulus state
   logic [15:0] lfsr_state;
   logic        stall_on;
   // Beats seen on the interconnect side
   int          uav_write_beats = 0;
   int          uav_read_cmds = 0;

   master_translator DUT (
      .clk             (clk),
      .reset           (reset),
      .av_cmd          (av_cmd),
      .av_waitrequest  (av_waitrequest),
      .av_rsp          (av_rsp),
      .uav_cmd         (uav_cmd),
      .uav_waitrequest (uav_waitrequest),
      .uav_rsp         (uav_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Count accepted commands once waitrequest has settled at the falling edge
   always @(negedge clk) begin
      if (!reset && !uav_waitrequest) begin
         if (uav_cmd.write) begin
            uav_write_beats++;
         end
         if (uav_cmd.read) begin
            uav_read_cmds++;
         end
      end
   end

   // ----------------------------------------------------------------------
   // Random source and checking
   // ----------------------------------------------------------------------
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
   endfunction

   // One LFSR step per bit with the newest bit in bit 0
   task automatic next_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v          = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      assert (actual == expected) else begin
         $display("Error: time %0t, %s expected %0h actual %0h",
                  $time, name, expected, actual);
         $display("tests failed");
         $fatal(1);
      end
   endtask

   // Word address plus beat offset, in bytes
   function automatic logic [UAV_ADDR_W-1:0] byte_address(input logic [AV_ADDR_W-1:0] word,
                                                          input int k);
      return UAV_ADDR_W'((int'(word) + k) * SYMBOLS_PER_WORD);
   endfunction

   function automatic logic [UAV_BURST_W-1:0] byte_count(input int words);
      return UAV_BURST_W'(words * SYMBOLS_PER_WORD);
   endfunction

   // ----------------------------------------------------------------------
   // Slave model and master driver
   // ----------------------------------------------------------------------
   // Slave back-pressure for the coming cycle
   task automatic stall_step();
      logic [31:0] r;
      next_bits(1, r);
      uav_waitrequest <= stall_on & r[0];
   endtask

   // Hold one beat until accepted and check the translated command every cycle
   task automatic send_beat(input av_cmd_t cmd, input logic [UAV_ADDR_W-1:0] exp_addr,
                            input logic [UAV_BURST_W-1:0] exp_count);
      logic accepted;
      accepted = 1'b0;
      av_cmd <= cmd;
      while (!accepted) begin
         stall_step();
         @(negedge clk);
         check_value("uav_cmd.write", 64'(cmd.write), 64'(uav_cmd.write));
         check_value("uav_cmd.read", 64'(cmd.read), 64'(uav_cmd.read));
         check_value("uav_cmd.address", 64'(exp_addr), 64'(uav_cmd.address));
         check_value("uav_cmd.burstcount", 64'(exp_count), 64'(uav_cmd.burstcount));
         check_value("uav_cmd.byteenable", 64'(cmd.byteenable), 64'(uav_cmd.byteenable));
         check_value("uav_cmd.writedata", 64'(cmd.writedata), 64'(uav_cmd.writedata));
         check_value("av_waitrequest", 64'(uav_waitrequest), 64'(av_waitrequest));
         accepted = !uav_waitrequest;
         @(posedge clk);
      end
   endtask

   task automatic idle_cycles(input int n);
      av_cmd <= '0;
      for (int i = 0; i < n; i++) begin
         stall_step();
         @(negedge clk);
         check_value("uav_cmd.write", 64'(1'b0), 64'(uav_cmd.write));
         check_value("uav_cmd.read", 64'(1'b0), 64'(uav_cmd.read));
         check_value("av_waitrequest", 64'(uav_waitrequest), 64'(av_waitrequest));
         @(posedge clk);
      end
   endtask

   // Beat k carries byte address (A+k)*4 and byte count (N-k)*4
   task automatic write_burst(input logic [AV_ADDR_W-1:0] base, input int n);
      av_cmd_t     cmd;
      logic [31:0] r;
      int          start;
      start = uav_write_beats;
      for (int k = 0; k < n; k++) begin
         cmd            = '0;
         cmd.write      = 1'b1;
         cmd.address    = base;
         cmd.burstcount = AV_BURST_W'(n);
         next_bits(4, r);
         cmd.byteenable = r[3:0];
         next_bits(32, r);
         cmd.writedata  = r;
         send_beat(cmd, byte_address(base, k), byte_count(n - k));
      end
      check_value("uav write beats", 64'(n), 64'(uav_write_beats - start));
   endtask

   // One command, then N data words from the slave
   task automatic read_burst(input logic [AV_ADDR_W-1:0] base, input int n);
      av_cmd_t     cmd;
      rsp_t        rsp;
      logic [31:0] r;
      int          start;
      start          = uav_read_cmds;
      cmd            = '0;
      cmd.read       = 1'b1;
      cmd.address    = base;
      cmd.burstcount = AV_BURST_W'(n);
      send_beat(cmd, byte_address(base, 0), byte_count(n));
      av_cmd <= '0;
      for (int k = 0; k < n; k++) begin
         next_bits(32, r);
         rsp               = '0;
         rsp.readdata      = r;
         rsp.readdatavalid = 1'b1;
         uav_rsp <= rsp;
         stall_step();
         @(negedge clk);
         check_value("av_rsp.readdata", 64'(r), 64'(av_rsp.readdata));
         check_value("av_rsp.readdatavalid", 64'(1'b1), 64'(av_rsp.readdatavalid));
         @(posedge clk);
      end
      uav_rsp <= '0;
      check_value("uav read commands", 64'(1), 64'(uav_read_cmds - start));
   endtask

   task automatic write_response();
      rsp_t        rsp;
      logic [31:0] r;
      av_cmd <= '0;
      next_bits(2, r);
      rsp                    = '0;
      rsp.response           = r[1:0];
      rsp.writeresponsevalid = 1'b1;
      uav_rsp <= rsp;
      stall_step();
      @(negedge clk);
      check_value("av_rsp.response", 64'(rsp.response), 64'(av_rsp.response));
      check_value("av_rsp.writeresponsevalid", 64'(1'b1), 64'(av_rsp.writeresponsevalid));
      @(posedge clk);
      uav_rsp <= '0;
   endtask

   // ----------------------------------------------------------------------
   // Directed tests
   // ----------------------------------------------------------------------
   // Idle master, random back-pressure and response traffic
   task automatic idle_after_reset();
      rsp_t        rsp;
      logic [31:0] r;
      stall_on = 1'b1;
      av_cmd <= '0;
      for (int i = 0; i < 8; i++) begin
         next_bits(32, r);
         rsp          = '0;
         rsp.readdata = r;
         next_bits(4, r);
         rsp.readdatavalid      = r[0];
         rsp.response           = r[2:1];
         rsp.writeresponsevalid = r[3];
         uav_rsp <= rsp;
         stall_step();
         @(negedge clk);
         check_value("uav_cmd.write", 64'(1'b0), 64'(uav_cmd.write));
         check_value("uav_cmd.read", 64'(1'b0), 64'(uav_cmd.read));
         check_value("av_waitrequest", 64'(uav_waitrequest), 64'(av_waitrequest));
         check_value("av_rsp", 64'(rsp), 64'(av_rsp));
         @(posedge clk);
      end
      uav_rsp <= '0;
   endtask

   task automatic single_word_write();
      logic [31:0] r;
      next_bits(16, r);
      write_burst(AV_ADDR_W'(r), 1);
      idle_cycles(2);
   endtask

   task automatic stalled_write_burst();
      logic [31:0] r;
      next_bits(16, r);
      write_burst(AV_ADDR_W'(r), 6);
      idle_cycles(2);
   endtask

   task automatic read_burst_return();
      logic [31:0] r;
      next_bits(16, r);
      read_burst(AV_ADDR_W'(r), 5);
      idle_cycles(2);
   endtask

   // Second burst starts on the cycle after the first one ends
   task automatic back_to_back_bursts();
      logic [31:0] r;
      next_bits(16, r);
      write_burst(AV_ADDR_W'(r), 4);
      next_bits(16, r);
      write_burst(AV_ADDR_W'(r), 3);
      write_response();
      next_bits(16, r);
      read_burst(AV_ADDR_W'(r), 4);
      idle_cycles(2);
   endtask

   initial begin
      av_cmd          = '0;
      uav_waitrequest = 1'b0;
      uav_rsp         = '0;
      reset           = 1'b1;
      stall_on        = 1'b0;
      lfsr_state      = LFSR_SEED;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      idle_after_reset();
      single_word_write();
      stalled_write_burst();
      read_burst_return();
      back_to_back_bursts();
      $display("all tests passed");
      $finish;
   end

   // Watchdog
   initial begin
      #((NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES) * CLK_PERIOD);
      $display("Timeout: the tests did not finish in the allowed time");
      $display("tests failed");
      $fatal(1);
   end

endmodule

/* vlog.f */
verilog/translator_pkg.sv
verilog/transfer_tracker.sv
verilog/burst_sequencer.sv
verilog/master_translator.sv
tb/tb_master_translator.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_master_translator
FILELIST = vlog.f
OBJ_DIR  = obj_dir
PASS_MSG = all tests passed

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
